//--- Makefile
SIM := obj_dir/Vconv_layer_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

$(SIM): verilog.f $(wildcard design/*.sv dv/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module conv_layer_tb

clean:
	rm -rf obj_dir

//--- design/conv_layer_top.sv
`timescale 1ns/100ps

module conv_layer_top (
    input  logic                clk,
    input  logic                i_arst_n,
    input  conv_pkg::conv_in_t  i_in,
    input  logic                i_in_valid,
    input  logic                i_load_weights,
    output logic                o_in_rdy,
    output conv_pkg::conv_out_t o_out,
    input  logic                i_out_rdy
);

    conv_pkg::wt_wr_t  wt_wr;
    conv_pkg::sample_t smp;
    logic              smp_strobe;
    logic              last_smp;
    logic              exec_busy;
    logic              frame_done;
    logic              acc_rd_en;
    conv_pkg::addr_t   acc_rd_addr;
    conv_pkg::q_t      acc_rd_data;
    logic              sending;

    // Input side, weight routing and duplicate filter
    conv_sample_decode decode_i (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_in           (i_in),
        .i_in_valid     (i_in_valid),
        .i_load_weights (i_load_weights),
        .i_exec_busy    (exec_busy),
        .i_sending      (sending),
        .o_in_rdy       (o_in_rdy),
        .o_wt_wr        (wt_wr),
        .o_smp          (smp),
        .o_smp_strobe   (smp_strobe),
        .o_last_smp     (last_smp)
    );

    conv_scatter_exec exec_i (
        .clk (clk), .i_arst_n (i_arst_n),
        .i_wt_wr (wt_wr), .i_smp (smp), .i_smp_strobe (smp_strobe), .i_last_smp (last_smp),
        .i_acc_rd_en (acc_rd_en), .i_acc_rd_addr (acc_rd_addr),
        .o_exec_busy (exec_busy), .o_frame_done (frame_done), .o_acc_rd_data (acc_rd_data)
    );

    conv_relu_result result_i (
        .clk (clk), .i_arst_n (i_arst_n),
        .i_frame_done (frame_done), .i_out_rdy (i_out_rdy), .i_acc_rd_data (acc_rd_data),
        .o_acc_rd_en (acc_rd_en), .o_acc_rd_addr (acc_rd_addr),
        .o_sending (sending), .o_out (o_out)
    );

endmodule

//--- design/conv_pkg.sv
package conv_pkg;

    // Layer geometry
    localparam int IN_SIZE     = 5;
    localparam int KERNEL_SIZE = 3;
    localparam int OUT_SIZE    = IN_SIZE - KERNEL_SIZE + 1;
    localparam int OUT_DEPTH   = 2;
    localparam int Q_FRAC      = 15;                            // Fraction bits
    localparam int N_WEIGHTS   = OUT_DEPTH * KERNEL_SIZE * KERNEL_SIZE;
    localparam int N_OUTPUTS   = OUT_DEPTH * OUT_SIZE * OUT_SIZE;

    localparam int COORD_W = 3;
    localparam int CH_W    = 1;
    localparam int ADDR_W  = 5;                                 // Covers both memories

    typedef logic [31:0]         q_t;                           // Sign bit 31, magnitude below
    typedef logic [COORD_W-1:0]  coord_t;
    typedef logic [CH_W-1:0]     ch_t;
    typedef logic [ADDR_W-1:0]   addr_t;

    typedef struct packed {
        q_t     data;
        ch_t    ch;
        coord_t x;
        coord_t y;
    } conv_in_t;

    typedef struct packed {
        q_t     data;
        coord_t x;
        coord_t y;
    } sample_t;

    typedef struct packed {
        logic   strobe;
        ch_t    ch;
        coord_t kx;
        coord_t ky;
        q_t     data;
    } wt_wr_t;

    typedef struct packed {
        logic   valid;
        q_t     data;
        ch_t    ch;
        coord_t x;
        coord_t y;
    } conv_out_t;

    // Weight memory index, ky runs fastest
    function automatic addr_t wt_addr(input ch_t ch, input coord_t kx, input coord_t ky);
        return addr_t'(int'(ch) * KERNEL_SIZE * KERNEL_SIZE + int'(kx) * KERNEL_SIZE + int'(ky));
    endfunction

    // Accumulator index in channel, x, y order
    function automatic addr_t acc_addr(input ch_t ch, input coord_t x, input coord_t y);
        return addr_t'(int'(ch) * OUT_SIZE * OUT_SIZE + int'(x) * OUT_SIZE + int'(y));
    endfunction

    function automatic q_t q_mul(input q_t a, input q_t b);
        logic [61:0] prod;
        q_t          r;
        prod     = a[30:0] * b[30:0];
        r[31]    = a[31] ^ b[31];
        r[30:0]  = prod[Q_FRAC +: 31];                          // Drop low fraction bits
        return r;
    endfunction

    function automatic q_t q_add(input q_t a, input q_t b);
        q_t r;
        if (a[31] == b[31]) begin
            r[30:0] = a[30:0] + b[30:0];
            r[31]   = a[31];
        end else if (a[30:0] > b[30:0]) begin
            r[30:0] = a[30:0] - b[30:0];
            r[31]   = a[31];
        end else begin
            r[30:0] = b[30:0] - a[30:0];
            r[31]   = b[31];
        end
        if (r[30:0] == '0) r[31] = 1'b0;                        // No negative zero
        return r;
    endfunction

endpackage

//--- design/conv_relu_result.sv
`timescale 1ns/100ps

module conv_relu_result (
    input  logic                clk,
    input  logic                i_arst_n,
    input  logic                i_frame_done,
    input  logic                i_out_rdy,
    input  conv_pkg::q_t        i_acc_rd_data,
    output logic                o_acc_rd_en,
    output conv_pkg::addr_t     o_acc_rd_addr,
    output logic                o_sending,
    output conv_pkg::conv_out_t o_out
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_READ,     // Request one accumulator
        S_SHOW      // Present it until the sink takes it
    } state_t;

    state_t           state_q;
    conv_pkg::ch_t    ch_q;
    conv_pkg::coord_t x_q;
    conv_pkg::coord_t y_q;
    logic             last_entry;

    assign last_entry = (int'(ch_q) == conv_pkg::OUT_DEPTH - 1) &&
                        (int'(x_q) == conv_pkg::OUT_SIZE - 1) &&
                        (int'(y_q) == conv_pkg::OUT_SIZE - 1);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= S_IDLE;
            ch_q    <= '0;
            x_q     <= '0;
            y_q     <= '0;
        end else begin
            case (state_q)
                S_IDLE: if (i_frame_done) state_q <= S_READ;
                S_READ: state_q <= S_SHOW;
                S_SHOW: begin
                    if (i_out_rdy) begin
                        state_q <= last_entry ? S_IDLE : S_READ;
                        if (last_entry) begin
                            ch_q <= '0;
                            x_q  <= '0;
                            y_q  <= '0;
                        end else if (int'(y_q) == conv_pkg::OUT_SIZE - 1) begin
                            y_q <= '0;
                            if (int'(x_q) == conv_pkg::OUT_SIZE - 1) begin
                                x_q  <= '0;
                                ch_q <= ch_q + 1'b1;
                            end else begin
                                x_q <= x_q + 1'b1;
                            end
                        end else begin
                            y_q <= y_q + 1'b1;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign o_acc_rd_en   = (state_q == S_READ);
    assign o_acc_rd_addr = conv_pkg::acc_addr(ch_q, x_q, y_q);
    assign o_sending     = (state_q != S_IDLE);

    // Read data stays put until the next request, so the word holds under back-pressure
    assign o_out = '{valid: (state_q == S_SHOW),
                     data:  i_acc_rd_data[31] ? '0 : i_acc_rd_data,   // ReLU
                     ch:    ch_q,
                     x:     x_q,
                     y:     y_q};

endmodule

//--- design/conv_sample_decode.sv
`timescale 1ns/100ps

module conv_sample_decode (
    input  logic                clk,
    input  logic                i_arst_n,
    input  conv_pkg::conv_in_t  i_in,
    input  logic                i_in_valid,
    input  logic                i_load_weights,
    input  logic                i_exec_busy,
    input  logic                i_sending,
    output logic                o_in_rdy,
    output conv_pkg::wt_wr_t    o_wt_wr,
    output conv_pkg::sample_t   o_smp,
    output logic                o_smp_strobe,
    output logic                o_last_smp
);

    conv_pkg::conv_in_t in_q;       // Last accepted word
    conv_pkg::coord_t   last_x_q;
    conv_pkg::coord_t   last_y_q;
    logic               wt_strobe_q;
    logic               smp_strobe_q;
    logic               accept;
    logic               dup;

    // Hold off while a strobe is in flight, a sweep runs or results stream
    assign o_in_rdy = !(wt_strobe_q || smp_strobe_q) && !i_exec_busy && !i_sending;
    assign accept   = i_in_valid && o_in_rdy;
    assign dup      = (i_in.x == last_x_q) && (i_in.y == last_y_q);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wt_strobe_q  <= 1'b0;
            smp_strobe_q <= 1'b0;
            last_x_q     <= conv_pkg::coord_t'(conv_pkg::IN_SIZE - 1);
            last_y_q     <= conv_pkg::coord_t'(conv_pkg::IN_SIZE - 1);
        end else begin
            wt_strobe_q  <= accept && i_load_weights;
            smp_strobe_q <= accept && !i_load_weights && !dup;
            if (accept && !i_load_weights && !dup) begin
                last_x_q <= i_in.x;
                last_y_q <= i_in.y;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) in_q <= i_in;
    end

    // Weight words reuse x, y as the kernel position
    assign o_wt_wr = '{strobe: wt_strobe_q, ch: in_q.ch, kx: in_q.x, ky: in_q.y,
                       data: in_q.data};
    assign o_smp   = '{data: in_q.data, x: in_q.x, y: in_q.y};
    assign o_smp_strobe = smp_strobe_q;
    assign o_last_smp   = (int'(in_q.x) == conv_pkg::IN_SIZE - 1) &&
                          (int'(in_q.y) == conv_pkg::IN_SIZE - 1);

endmodule

//--- design/conv_scatter_exec.sv
`timescale 1ns/100ps

module conv_scatter_exec (
    input  logic                clk,
    input  logic                i_arst_n,
    input  conv_pkg::wt_wr_t    i_wt_wr,
    input  conv_pkg::sample_t   i_smp,
    input  logic                i_smp_strobe,
    input  logic                i_last_smp,
    input  logic                i_acc_rd_en,
    input  conv_pkg::addr_t     i_acc_rd_addr,
    output logic                o_exec_busy,
    output logic                o_frame_done,
    output conv_pkg::q_t        o_acc_rd_data
);

    conv_pkg::q_t wt_mem  [conv_pkg::N_WEIGHTS];
    conv_pkg::q_t acc_mem [conv_pkg::N_OUTPUTS];

    conv_pkg::sample_t smp_q;
    conv_pkg::q_t      wt_rd_q;
    conv_pkg::q_t      acc_rd_q;
    conv_pkg::q_t      rd_data_q;
    conv_pkg::q_t      mac;

    logic              busy_q;
    logic              phase_q;    // Low reads, high writes
    logic              last_q;     // Sweep belongs to the final sample
    conv_pkg::ch_t     ch_q;
    conv_pkg::coord_t  kx_q;
    conv_pkg::coord_t  ky_q;

    conv_pkg::coord_t  tx;
    conv_pkg::coord_t  ty;
    logic              in_range;
    logic              last_step;
    conv_pkg::addr_t   wt_idx;
    conv_pkg::addr_t   acc_idx;

    // Output position hit by this kernel tap
    assign tx = smp_q.x - kx_q;
    assign ty = smp_q.y - ky_q;
    assign in_range = (smp_q.x >= kx_q) && (int'(tx) < conv_pkg::OUT_SIZE) &&
                      (smp_q.y >= ky_q) && (int'(ty) < conv_pkg::OUT_SIZE);

    assign wt_idx  = conv_pkg::wt_addr(ch_q, kx_q, ky_q);
    assign acc_idx = in_range ? conv_pkg::acc_addr(ch_q, tx, ty) : '0;

    assign last_step = (int'(ch_q) == conv_pkg::OUT_DEPTH - 1) &&
                       (int'(kx_q) == conv_pkg::KERNEL_SIZE - 1) &&
                       (int'(ky_q) == conv_pkg::KERNEL_SIZE - 1);

    assign mac = conv_pkg::q_add(acc_rd_q, conv_pkg::q_mul(wt_rd_q, smp_q.data));

    // Sweep control, channel outermost and ky innermost
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q  <= 1'b0;
            phase_q <= 1'b0;
            last_q  <= 1'b0;
            ch_q    <= '0;
            kx_q    <= '0;
            ky_q    <= '0;
        end else if (i_smp_strobe) begin
            busy_q  <= 1'b1;
            phase_q <= 1'b0;
            last_q  <= i_last_smp;
            ch_q    <= '0;
            kx_q    <= '0;
            ky_q    <= '0;
        end else if (busy_q) begin
            phase_q <= ~phase_q;
            if (phase_q) begin
                if (last_step) begin
                    busy_q <= 1'b0;
                    ch_q   <= '0;
                    kx_q   <= '0;
                    ky_q   <= '0;
                end else if (int'(ky_q) == conv_pkg::KERNEL_SIZE - 1) begin
                    ky_q <= '0;
                    if (int'(kx_q) == conv_pkg::KERNEL_SIZE - 1) begin
                        kx_q <= '0;
                        ch_q <= ch_q + 1'b1;
                    end else begin
                        kx_q <= kx_q + 1'b1;
                    end
                end else begin
                    ky_q <= ky_q + 1'b1;
                end
            end
        end
    end

    // Sample latch, read-cycle fetches, weight writes and result reads
    always_ff @(posedge clk) begin
        if (i_smp_strobe) smp_q <= i_smp;
        if (busy_q && !phase_q) begin
            wt_rd_q  <= wt_mem[wt_idx];
            acc_rd_q <= acc_mem[acc_idx];
        end
        if (i_wt_wr.strobe) begin
            wt_mem[conv_pkg::wt_addr(i_wt_wr.ch, i_wt_wr.kx, i_wt_wr.ky)] <= i_wt_wr.data;
        end
        if (i_acc_rd_en) rd_data_q <= acc_mem[i_acc_rd_addr];
    end

    // Accumulators start at zero and clear as they are read out
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < conv_pkg::N_OUTPUTS; i++) acc_mem[i] <= '0;
        end else if (busy_q && phase_q && in_range) begin
            acc_mem[acc_idx] <= mac;
        end else if (i_acc_rd_en) begin
            acc_mem[i_acc_rd_addr] <= '0;
        end
    end

    assign o_exec_busy   = busy_q;
    assign o_frame_done  = busy_q && phase_q && last_step && last_q;
    assign o_acc_rd_data = rd_data_q;

endmodule

//--- dv/conv_layer_chk.sv
`timescale 1ns/100ps

module conv_layer_chk (
    input  logic                clk,
    input  logic                i_arst_n,
    input  conv_pkg::conv_out_t i_out,
    input  logic                i_out_rdy,
    input  logic                i_in_rdy
);

    // A presented word stays put until the sink takes it
    hold_until_taken: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        (i_out.valid && !i_out_rdy) |=> $stable(i_out)
    ) else $error("o_out changed while i_out_rdy was low");

    no_valid_in_reset: assert property (
        @(posedge clk) !i_arst_n |-> !i_out.valid
    ) else $error("o_out.valid high during reset");

    // Input side waits while results stream
    no_input_while_sending: assert property (
        @(posedge clk) disable iff (!i_arst_n)
        i_out.valid |-> !i_in_rdy
    ) else $error("o_in_rdy high while o_out.valid is high");

endmodule

bind conv_layer_top conv_layer_chk chk_i (
    .clk       (clk),
    .i_arst_n  (i_arst_n),
    .i_out     (o_out),
    .i_out_rdy (i_out_rdy),
    .i_in_rdy  (o_in_rdy)
);

//--- dv/conv_layer_tb.sv
`timescale 1ns/100ps

module conv_layer_tb;

    localparam int K       = conv_pkg::KERNEL_SIZE;
    localparam int OS      = conv_pkg::OUT_SIZE;
    localparam int N_SMP   = conv_pkg::IN_SIZE * conv_pkg::IN_SIZE + 1;
    localparam int DUP_AT  = 8;             // Repeats the coordinates of entry 7
    localparam int N_FRAME = 3;
    localparam int TIMEOUT = 2000;          // Cycles allowed for any one wait

    logic                clk;
    logic                i_arst_n;
    conv_pkg::conv_in_t  i_in;
    logic                i_in_valid;
    logic                i_load_weights;
    logic                o_in_rdy;
    conv_pkg::conv_out_t o_out;
    logic                i_out_rdy;

    integer              seed = 32'h3226_e445;
    int                  errors;
    int                  checks;
    int                  out_seen;
    logic                rdy_random;
    int                  last_x;            // Model copy of the duplicate filter state
    int                  last_y;
    conv_pkg::q_t        exp_q[$];
    conv_pkg::q_t        frame_data [N_FRAME][N_SMP];
    conv_pkg::conv_out_t prev_out;
    logic                prev_wait;

    // Channel 0 leans positive and channel 1 negative with ky running fastest
    conv_pkg::q_t wt_tbl [conv_pkg::N_WEIGHTS] = '{
        32'h0000_8000, 32'h8000_4000, 32'h0001_0000, 32'h0000_2000, 32'h0000_C000, 32'h8000_2000,
        32'h0000_6000, 32'h0000_1234, 32'h8000_8000, 32'h8000_8000, 32'h8000_4000, 32'h0000_2000,
        32'h8000_C000, 32'h8001_0000, 32'h8000_1000, 32'h0000_4000, 32'h8000_6000, 32'h8000_2000
    };

    // Image values in raster order where entry DUP_AT carries a large value to be dropped
    conv_pkg::q_t smp_tbl [N_SMP] = '{
        32'h0000_8000, 32'h0001_0000, 32'h0000_4000, 32'h0001_2000, 32'h0000_1800,
        32'h0000_A000, 32'h0000_3000, 32'h0001_8000, 32'h0005_0000, 32'h0000_6800,
        32'h0000_E000, 32'h0000_2400, 32'h0001_4000, 32'h0000_7000, 32'h0000_9000,
        32'h0000_1000, 32'h0000_C000, 32'h0001_6000, 32'h0000_5000, 32'h0000_B000,
        32'h0000_2000, 32'h0001_C000, 32'h0000_8800, 32'h0000_4800, 32'h0000_F000,
        32'h0001_3579
    };

    conv_layer_top dut_i (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_in           (i_in),
        .i_in_valid     (i_in_valid),
        .i_load_weights (i_load_weights),
        .o_in_rdy       (o_in_rdy),
        .o_out          (o_out),
        .i_out_rdy      (i_out_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int raster_idx(input int i);
        return (i < DUP_AT) ? i : i - 1;    // Entry DUP_AT reuses the previous position
    endfunction

    function automatic conv_pkg::q_t fixed_mul(input conv_pkg::q_t a, input conv_pkg::q_t b);
        logic [63:0] prod;
        prod = 64'(a[30:0]) * 64'(b[30:0]);
        return {a[31] ^ b[31], prod[45:15]};
    endfunction

    // Sign-magnitude sum done in two's complement
    function automatic conv_pkg::q_t fixed_add(input conv_pkg::q_t a, input conv_pkg::q_t b);
        longint va;
        longint vb;
        longint sum;
        va  = a[31] ? -longint'(a[30:0]) : longint'(a[30:0]);
        vb  = b[31] ? -longint'(b[30:0]) : longint'(b[30:0]);
        sum = va + vb;
        if (sum < 0) return {1'b1, 31'(-sum)};
        return {1'b0, 31'(sum)};
    endfunction

    // Scatter every kept sample of one frame, then ReLU into the expected queue
    task automatic build_expected(input int f);
        conv_pkg::q_t acc [conv_pkg::N_OUTPUTS];
        int x;
        int y;
        int tx;
        int ty;
        int o;
        for (int j = 0; j < conv_pkg::N_OUTPUTS; j++) acc[j] = '0;
        for (int i = 0; i < N_SMP; i++) begin
            x = raster_idx(i) % conv_pkg::IN_SIZE;
            y = raster_idx(i) / conv_pkg::IN_SIZE;
            if (x == last_x && y == last_y) continue;
            last_x = x;
            last_y = y;
            for (int w = 0; w < conv_pkg::N_WEIGHTS; w++) begin
                tx = x - (w / K) % K;
                ty = y - w % K;
                if (tx >= 0 && tx < OS && ty >= 0 && ty < OS) begin
                    o      = (w / (K * K)) * OS * OS + tx * OS + ty;
                    acc[o] = fixed_add(acc[o], fixed_mul(wt_tbl[w], frame_data[f][i]));
                end
            end
        end
        for (int j = 0; j < conv_pkg::N_OUTPUTS; j++) exp_q.push_back(acc[j][31] ? '0 : acc[j]);
    endtask

    task automatic check_q(input string name, input conv_pkg::q_t exp, input conv_pkg::q_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_coord(input string name, input conv_pkg::coord_t exp,
                               input conv_pkg::coord_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout: %s", what);
        $display("SIMULATION FAILED");
        $finish;
    endtask

    task automatic send_word(input conv_pkg::conv_in_t word, input logic load);
        int waited;
        @(posedge clk);
        i_in           <= word;
        i_in_valid     <= 1'b1;
        i_load_weights <= load;
        waited = 0;
        @(negedge clk);
        while (!o_in_rdy) begin
            if (waited == TIMEOUT)
                abort_run("o_in_rdy stayed low and the input word was not taken");
            waited++;
            @(negedge clk);
        end
        @(posedge clk);                     // Accepted on this edge
        i_in_valid <= 1'b0;
    endtask

    task automatic take_output();
        string name;
        int    j;
        j    = out_seen % conv_pkg::N_OUTPUTS;
        name = $sformatf("frame %0d out %0d", out_seen / conv_pkg::N_OUTPUTS, j);
        if (exp_q.size() == 0) begin
            errors++;
            $display("Output word %0d arrived while no result was expected", out_seen);
        end else begin
            check_q($sformatf("%s data", name), exp_q.pop_front(), o_out.data);
            check_coord($sformatf("%s ch", name), conv_pkg::coord_t'(j / (OS * OS)),
                        conv_pkg::coord_t'(o_out.ch));
            check_coord($sformatf("%s x", name), conv_pkg::coord_t'((j / OS) % OS), o_out.x);
            check_coord($sformatf("%s y", name), conv_pkg::coord_t'(j % OS), o_out.y);
        end
        out_seen++;
    endtask

    // Sink with optional random gaps
    always @(posedge clk) begin
        if (rdy_random) i_out_rdy <= ($random(seed) & 3) != 0;
        else i_out_rdy <= 1'b1;
    end

    // Output side sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (i_arst_n && prev_wait && o_out !== prev_out) begin
            errors++;
            $display("o_out changed before the sink accepted it");
        end
        if (i_arst_n && o_out.valid) begin
            if (o_in_rdy) begin
                errors++;
                $display("o_in_rdy is high while an output word is pending");
            end
            if (i_out_rdy) take_output();
        end
        prev_wait = i_arst_n && o_out.valid && !i_out_rdy;
        prev_out  = o_out;
    end

    initial begin
        conv_pkg::conv_in_t word;
        int                 stall;
        int                 waited;
        i_arst_n       = 1'b0;
        i_in           = '0;
        i_in_valid     = 1'b0;
        i_load_weights = 1'b0;
        i_out_rdy      = 1'b0;
        rdy_random     = 1'b0;
        prev_wait      = 1'b0;
        prev_out       = '0;
        errors         = 0;
        checks         = 0;
        out_seen       = 0;
        last_x         = conv_pkg::IN_SIZE - 1;
        last_y         = conv_pkg::IN_SIZE - 1;
        for (int i = 0; i < N_SMP; i++) begin
            frame_data[0][i] = smp_tbl[i];
            frame_data[1][i] = smp_tbl[i] ^ 32'h8000_0000;     // Same magnitudes with sign flipped
            frame_data[2][i] = $random(seed) & 32'h8001_FFFF;  // Below 4.0 in either sign
        end
        @(posedge clk);
        @(negedge clk);
        check_flag("during reset o_out.valid", 1'b0, o_out.valid);
        @(posedge clk);
        i_arst_n <= 1'b1;
        @(negedge clk);
        check_flag("after reset o_in_rdy", 1'b1, o_in_rdy);
        check_flag("after reset o_out.valid", 1'b0, o_out.valid);

        for (int w = 0; w < conv_pkg::N_WEIGHTS; w++) begin
            word = '{data: wt_tbl[w], ch: conv_pkg::ch_t'(w / (K * K)),
                     x: conv_pkg::coord_t'((w / K) % K), y: conv_pkg::coord_t'(w % K)};
            send_word(word, 1'b1);
        end

        for (int f = 0; f < N_FRAME; f++) begin
            rdy_random <= (f != 0);
            build_expected(f);
            for (int i = 0; i < N_SMP; i++) begin
                word = '{data: frame_data[f][i], ch: '0,
                         x: conv_pkg::coord_t'(raster_idx(i) % conv_pkg::IN_SIZE),
                         y: conv_pkg::coord_t'(raster_idx(i) / conv_pkg::IN_SIZE)};
                send_word(word, 1'b0);
            end
            stall = 1;
            @(negedge clk);
            while (!o_out.valid) begin
                if (stall == TIMEOUT) abort_run("no output after the last sample of a frame");
                stall++;
                @(negedge clk);
            end
            if (stall < 2 * conv_pkg::N_WEIGHTS) begin
                errors++;
                $display("Frame %0d output came %0d cycles after the last sample, mid sweep",
                         f, stall);
            end
            waited = 0;
            while (out_seen < (f + 1) * conv_pkg::N_OUTPUTS) begin
                if (waited == TIMEOUT) abort_run("not all results of a frame were streamed");
                waited++;
                @(posedge clk);
            end
        end

        repeat (4) @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results never arrived", exp_q.size());
        end
        $display("Finished: %0d outputs, %0d checks, %0d errors", out_seen, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
design/conv_pkg.sv
design/conv_sample_decode.sv
design/conv_scatter_exec.sv
design/conv_relu_result.sv
design/conv_layer_top.sv
dv/conv_layer_chk.sv
dv/conv_layer_tb.sv
